/* all.f */
+incdir+include
verilog/vc_pkg.sv
verilog/class_demux.sv
verilog/vc_fifo.sv
verilog/priority_arbiter.sv
verilog/dest_router.sv
verilog/vc_switch_top.sv
sim/vc_switch_tb.sv

/* include/vc_cfg.svh */
`ifndef VC_CFG_SVH
`define VC_CFG_SVH

// Switch word layout
// Bit 5 is the class, bit 4 the destination, bits 3..0 the payload
`define VC_WORD_WIDTH 6

// Words held by each class FIFO
`define VC_FIFO_DEPTH 4

// Occupancy thresholds for the status flags
`define VC_ALMOST_EMPTY 1   // Almost empty at or below this, when not empty
`define VC_ALMOST_FULL 3    // Almost full and pause at or above this

// Bit positions inside a word
`define VC_CLASS_BIT (`VC_WORD_WIDTH - 1)
`define VC_DEST_BIT (`VC_WORD_WIDTH - 2)

`endif

/* run_sim.sh */
#!/bin/sh
# Compile and run the switch testbench with Verilator
# The result is read from the simulation log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps --top-module vc_switch_tb \
    -f all.f -o vc_switch_sim > build.log 2>&1 \
    && ./obj_dir/vc_switch_sim > sim.log 2>&1 \
    || { echo "Build or run error, see build.log and sim.log"; exit 1; }
grep -q "Test failed" sim.log \
    && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }

/* sim/vc_switch_tb.sv */
`include "vc_cfg.svh"

module vc_switch_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import vc_pkg::*;

    localparam int clk_period = 100;
    localparam int budget_cycles = 10 + 80 + 60 + 60 + 200;   // Reset, routes, order, fill, random
    localparam int margin_cycles = 100;

    logic         clk;
    logic         reset_L;
    word_t        word_data;
    logic         word_valid;
    logic         hold;
    fifo_status_t status_hi, status_lo;
    payload_t     dest0_data, dest1_data;
    logic         dest0_valid, dest1_valid;

    // Reference model, stepped at each falling edge for the coming rising edge
    word_t    mq_hi[$];        // Words the high FIFO holds
    word_t    mq_lo[$];
    payload_t exp0[$];         // Predicted order on destination 0
    payload_t exp1[$];
    logic     dm_valid;        // Word waiting in the demux register
    word_t    dm_word;

    string       test_name;
    int          monitor_errors;   // Output mismatches
    int          check_errors;     // Status, latency and drain failures
    int          outputs_seen;
    int          err_pulses;       // Error pulses from either FIFO

    vc_switch_top dut (
        .clk(clk), .reset_L(reset_L),
        .word_data(word_data), .word_valid(word_valid), .hold(hold),
        .status_hi(status_hi), .status_lo(status_lo),
        .dest0_data(dest0_data), .dest0_valid(dest0_valid),
        .dest1_data(dest1_data), .dest1_valid(dest1_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Watchdog
    initial begin
        #((budget_cycles + margin_cycles) * clk_period);
        $display("Watchdog expired after %0d cycles", budget_cycles + margin_cycles);
        $display("Test failed");
        $finish;
    end

    function automatic word_t make_word(logic cls, logic dst, payload_t p);
        return {cls, dst, p};   // Class, destination, payload
    endfunction

    // Flags a FIFO must show when it holds n words
    function automatic fifo_status_t expected_status(int n, logic err);
        fifo_status_t s;
        s.empty = (n == 0);
        s.almost_empty = (n > 0) && (n <= `VC_ALMOST_EMPTY);
        s.almost_full = (n >= `VC_ALMOST_FULL);
        s.full = (n == `VC_FIFO_DEPTH);
        s.pause = s.almost_full;
        s.error = err;
        return s;
    endfunction

    task automatic compare_payload(payload_t expected, payload_t actual);
        if (actual !== expected) begin
            monitor_errors++;
            $display("FAIL %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic compare_status(fifo_status_t expected, fifo_status_t actual);
        if (actual !== expected) begin
            check_errors++;
            $display("FAIL %s: expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    task automatic record_output(logic dest, payload_t got);
        outputs_seen++;
        if (dest ? (exp1.size() == 0) : (exp0.size() == 0)) begin
            monitor_errors++;
            $display("Unexpected word %h on destination %0d in %s", got, dest, test_name);
        end else if (dest) begin
            compare_payload(exp1.pop_front(), got);
        end else begin
            compare_payload(exp0.pop_front(), got);
        end
    endtask

    task automatic step_model();
        logic  full_hi, full_lo;
        word_t w;
        full_hi = (mq_hi.size() == `VC_FIFO_DEPTH);   // Full before this edge's pop
        full_lo = (mq_lo.size() == `VC_FIFO_DEPTH);
        if (!hold && (mq_hi.size() > 0 || mq_lo.size() > 0)) begin
            if (mq_hi.size() > 0) w = mq_hi.pop_front();   // High class first
            else w = mq_lo.pop_front();
            if (w[`VC_DEST_BIT]) exp1.push_back(w[3:0]);
            else exp0.push_back(w[3:0]);
        end
        if (dm_valid && !dm_word[`VC_CLASS_BIT] && !full_hi) mq_hi.push_back(dm_word);
        if (dm_valid && dm_word[`VC_CLASS_BIT] && !full_lo) mq_lo.push_back(dm_word);
        dm_valid = word_valid;   // Captured at the coming edge
        dm_word = word_data;
    endtask

    // Output monitor and model step
    always @(negedge clk) begin
        if (!reset_L) begin
            mq_hi.delete();
            mq_lo.delete();
            exp0.delete();
            exp1.delete();
            dm_valid = 1'b0;
        end else begin
            if (dest0_valid) record_output(1'b0, dest0_data);
            if (dest1_valid) record_output(1'b1, dest1_data);
            if (status_hi.error) err_pulses++;
            if (status_lo.error) err_pulses++;
            step_model();
        end
    end

    // Called at the drive point, returns at the next one
    task automatic send_word(word_t w);
        word_valid = 1'b1;
        word_data = w;
        @(posedge clk);
        #10;
        word_valid = 1'b0;
    endtask

    task automatic wait_drain(int max_cycles);
        int n;
        n = 0;
        while ((exp0.size() + exp1.size() + mq_hi.size() + mq_lo.size() > 0 || dm_valid)
               && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exp0.size() + exp1.size() + mq_hi.size() + mq_lo.size() > 0 || dm_valid) begin
            check_errors++;
            $display("Words of %s did not drain within %0d cycles", test_name, max_cycles);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic check_after_reset();
        test_name = "after_reset";
        repeat (3) begin
            @(negedge clk);
            compare_status(expected_status(0, 1'b0), status_hi);
            compare_status(expected_status(0, 1'b0), status_lo);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic send_each_route();
        word_t w;
        int    n;
        test_name = "each_route";
        for (int c = 0; c < 4; c++) begin
            w = make_word(c[1], c[0], payload_t'(c + 9));
            send_word(w);
            n = 0;
            do begin   // Edges after the sampling edge
                @(posedge clk);
                #1;
                n++;
            end while (!(c[0] ? dest1_valid : dest0_valid) && n < 8);
            if (n != 3) begin
                check_errors++;
                $display("FAIL %s: expected latency 3, actual %0d", test_name, n);
            end
            wait_drain(10);
        end
    endtask

    task automatic priority_order();
        int seen;
        test_name = "priority_order";
        seen = outputs_seen;
        hold = 1'b1;
        send_word(make_word(1'b1, 1'b0, 4'h1));   // Low class first
        send_word(make_word(1'b1, 1'b1, 4'h2));
        send_word(make_word(1'b1, 1'b0, 4'h3));
        send_word(make_word(1'b0, 1'b1, 4'h4));   // Then high class
        send_word(make_word(1'b0, 1'b0, 4'h5));
        send_word(make_word(1'b0, 1'b1, 4'h6));
        repeat (2) @(posedge clk);
        #10;
        compare_status(expected_status(3, 1'b0), status_hi);
        compare_status(expected_status(3, 1'b0), status_lo);
        if (outputs_seen != seen) begin
            check_errors++;
            $display("Words left the switch while hold was high");
        end
        hold = 1'b0;
        wait_drain(30);
    endtask

    task automatic fill_levels();
        int seen;
        test_name = "fill_levels";
        seen = outputs_seen;
        hold = 1'b1;
        for (int i = 1; i <= 5; i++) begin
            send_word(make_word(1'b0, i[0], payload_t'(i)));
            @(negedge clk);
            @(negedge clk);   // After the write edge
            if (i <= `VC_FIFO_DEPTH) begin
                compare_status(expected_status(i, 1'b0), status_hi);
            end else begin
                compare_status(expected_status(`VC_FIFO_DEPTH, 1'b1), status_hi);
                @(negedge clk);
                compare_status(expected_status(`VC_FIFO_DEPTH, 1'b0), status_hi);   // Pulse gone
            end
            @(posedge clk);   // Back to the drive point
            #10;
        end
        hold = 1'b0;
        wait_drain(30);
        if (outputs_seen - seen != `VC_FIFO_DEPTH) begin
            check_errors++;
            $display("FAIL %s: expected %0d words, actual %0d", test_name,
                     `VC_FIFO_DEPTH, outputs_seen - seen);
        end
        @(negedge clk);
        compare_status(expected_status(0, 1'b0), status_hi);
    endtask

    task automatic random_stream();
        word_t w;
        int    pulses;
        test_name = "random_stream";
        pulses = err_pulses;
        for (int i = 0; i < 120; i++) begin
            @(posedge clk);
            #10;
            hold = ($urandom_range(0, 3) == 0);
            w = word_t'($urandom_range(0, 63));
            // Push only while the class FIFO does not ask for a pause
            if ($urandom_range(0, 1) == 1 &&
                !(w[`VC_CLASS_BIT] ? status_lo.pause : status_hi.pause)) begin
                word_valid = 1'b1;
                word_data = w;
            end else begin
                word_valid = 1'b0;
            end
        end
        @(posedge clk);
        #10;
        word_valid = 1'b0;
        hold = 1'b0;
        wait_drain(60);
        if (err_pulses != pulses) begin
            check_errors++;
            $display("FIFO error pulse seen during %s", test_name);
        end
    endtask

    initial begin
        void'($urandom(20));
        reset_L = 1'b0;
        word_data = '0;
        word_valid = 1'b0;
        hold = 1'b0;
        test_name = "reset";
        repeat (2) @(posedge clk);
        #10;
        reset_L = 1'b1;
        check_after_reset();
        send_each_route();
        priority_order();
        fill_levels();
        random_stream();
        $display("Errors: %0d output, %0d check", monitor_errors, check_errors);
        if (monitor_errors + check_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verilog/class_demux.sv */
`include "vc_cfg.svh"

module class_demux (
    input  logic           clk,
    input  logic           reset_L,
    input  vc_pkg::word_t  word_data,   // Word from upstream
    input  logic           word_valid,  // Strobe, one word per cycle
    output logic           push_hi,     // Push for the class 0 FIFO
    output logic           push_lo,     // Push for the class 1 FIFO
    output vc_pkg::word_t  push_data    // Shared by both FIFOs
);
    import vc_pkg::*;

    logic push_q;   // Registered strobe
    word_t data_q;  // Registered word

    // Control register, cleared on reset
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            push_q <= 1'b0;
        end else begin
            push_q <= word_valid;
        end
    end

    // Payload register, only loads on a valid word
    always_ff @(posedge clk) begin
        if (word_valid) begin
            data_q <= word_data;
        end
    end

    // Steer the push by the class bit
    // Only one FIFO sees the strobe
    always_comb begin
        push_hi = push_q && !data_q[`VC_CLASS_BIT];   // Class 0, high priority
        push_lo = push_q && data_q[`VC_CLASS_BIT];    // Class 1, low priority
    end

    assign push_data = data_q;

endmodule

/* verilog/dest_router.sv */
`include "vc_cfg.svh"

module dest_router (
    input  logic               clk,
    input  logic               reset_L,
    input  vc_pkg::read_word_t read_word,     // From the arbiter
    output vc_pkg::payload_t   dest0_data,
    output vc_pkg::payload_t   dest1_data,
    output logic               dest0_valid,   // One cycle strobe per word
    output logic               dest1_valid
);
    import vc_pkg::*;

    logic     to_dest1;     // Destination bit of the incoming word
    payload_t payload;      // Low four bits of the word

    assign to_dest1 = read_word.word[`VC_DEST_BIT];
    assign payload = read_word.word[3:0];

    // Valid strobes, cleared on reset
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            dest0_valid <= 1'b0;
            dest1_valid <= 1'b0;
        end else begin
            dest0_valid <= read_word.valid && !to_dest1;
            dest1_valid <= read_word.valid && to_dest1;
        end
    end

    // Data only moves with a valid word for that port
    always_ff @(posedge clk) begin
        if (read_word.valid && !to_dest1) begin
            dest0_data <= payload;
        end
        if (read_word.valid && to_dest1) begin
            dest1_data <= payload;
        end
    end

endmodule

/* verilog/priority_arbiter.sv */
module priority_arbiter (
    input  logic               empty_hi,    // Empty flag, class 0 FIFO
    input  logic               empty_lo,    // Empty flag, class 1 FIFO
    input  logic               hold,        // Downstream stop, blocks all pops
    output logic               pop_hi,
    output logic               pop_lo,
    input  vc_pkg::word_t      read_hi,     // Read data from the class 0 FIFO
    input  vc_pkg::word_t      read_lo,     // Read data from the class 1 FIFO
    input  logic               valid_hi,
    input  logic               valid_lo,
    output vc_pkg::read_word_t read_word    // Merged and tagged
);
    import vc_pkg::*;

    logic grant_hi;     // High FIFO wins this cycle
    logic grant_lo;     // Low FIFO wins this cycle

    // Fixed priority
    // The high class always goes first, the low class only on an empty high FIFO
    always_comb begin
        grant_hi = !hold && !empty_hi;
        grant_lo = !hold && empty_hi && !empty_lo;
    end

    assign pop_hi = grant_hi;
    assign pop_lo = grant_lo;   // Never together with pop_hi

    // Merge the read side
    // At most one FIFO answers per cycle, so its valid picks the word
    always_comb begin
        read_word.valid = valid_hi || valid_lo;
        read_word.traffic_class = valid_lo;    // 1 only for a class 1 word
        if (valid_lo) begin
            read_word.word = read_lo;
        end else begin
            read_word.word = read_hi;          // Also idle value
        end
    end

endmodule

/* verilog/vc_fifo.sv */
`include "vc_cfg.svh"

module vc_fifo #(
    parameter int depth = `VC_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 reset_L,
    input  logic                 push,        // Write strobe
    input  logic                 pop,         // Read strobe, never while empty
    input  vc_pkg::word_t        push_data,
    output vc_pkg::word_t        read_data,   // One cycle after pop
    output logic                 read_valid,  // Marks read_data
    output vc_pkg::fifo_status_t status
);
    import vc_pkg::*;

    localparam int addr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [addr_width-1:0] last_addr = addr_width'(depth - 1);

    word_t mem [depth];                      // Storage array
    logic [addr_width-1:0] wr_ptr, rd_ptr;   // Write and read addresses
    count_t count;                           // Words held
    logic write_en;                          // Push that is accepted
    logic error_q;                           // Registered error pulse
    logic empty, full;

    // Flags straight from the count
    assign empty = (count == '0);
    assign full = (count == count_t'(depth));
    assign write_en = push && !full;         // A push into full is dropped

    // Storage, no reset
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at depth, so non power of two depths work too
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (write_en) begin
                wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + 1'b1;
            end
        end
    end

    // Occupancy
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            count <= '0;
        end else begin
            case ({write_en, pop})
                2'b10: count <= count + 1'b1;   // Write only
                2'b01: count <= count - 1'b1;   // Read only
                default: count <= count;        // Both or neither, count holds
            endcase
        end
    end

    // Error pulse for a dropped word
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            error_q <= 1'b0;
        end else begin
            error_q <= push && full;
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (!reset_L) begin
            read_valid <= 1'b0;
        end else begin
            read_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            read_data <= mem[rd_ptr];   // Holds last word otherwise
        end
    end

    // Status out
    always_comb begin
        status.empty = empty;
        status.almost_empty = !empty && (count <= count_t'(`VC_ALMOST_EMPTY));
        status.almost_full = (count >= count_t'(`VC_ALMOST_FULL));
        status.full = full;
        status.pause = status.almost_full;   // Upstream stops here
        status.error = error_q;
    end

endmodule

/* verilog/vc_pkg.sv */
`include "vc_cfg.svh"

package vc_pkg;

    typedef logic [`VC_WORD_WIDTH-1:0] word_t;      // Class, destination and payload
    typedef logic [3:0] payload_t;                  // Payload field alone

    // Occupancy 0 to depth, so one bit more than the address
    typedef logic [$clog2(`VC_FIFO_DEPTH + 1)-1:0] count_t;

    // FIFO status, packed MSB first
    typedef struct packed {
        logic empty;
        logic almost_empty;
        logic almost_full;
        logic full;
        logic pause;        // Same as almost full, tells upstream to stop
        logic error;        // One cycle pulse, push into full FIFO
    } fifo_status_t;

    // Read word from the arbiter to the router
    typedef struct packed {
        logic  valid;
        logic  traffic_class;   // 0 came from high FIFO, 1 from low FIFO
        word_t word;
    } read_word_t;

endpackage

/* verilog/vc_switch_top.sv */
module vc_switch_top (
    input  logic                 clk,
    input  logic                 reset_L,
    input  vc_pkg::word_t        word_data,
    input  logic                 word_valid,
    input  logic                 hold,        // Blocks all pops while high
    output vc_pkg::fifo_status_t status_hi,
    output vc_pkg::fifo_status_t status_lo,
    output vc_pkg::payload_t     dest0_data,
    output logic                 dest0_valid,
    output vc_pkg::payload_t     dest1_data,
    output logic                 dest1_valid
);
    import vc_pkg::*;

    logic       push_hi, push_lo;    // Demux to FIFOs
    word_t      push_data;
    logic       pop_hi, pop_lo;      // Arbiter to FIFOs
    word_t      read_hi, read_lo;    // FIFOs to arbiter
    logic       valid_hi, valid_lo;
    read_word_t read_word;           // Arbiter to router

    // Input side
    class_demux u_demux (
        .clk(clk), .reset_L(reset_L),
        .word_data(word_data), .word_valid(word_valid),
        .push_hi(push_hi), .push_lo(push_lo), .push_data(push_data)
    );

    // Class 0 queue
    vc_fifo fifo_hi (
        .clk(clk), .reset_L(reset_L),
        .push(push_hi), .pop(pop_hi), .push_data(push_data),
        .read_data(read_hi), .read_valid(valid_hi), .status(status_hi)
    );

    // Class 1 queue
    vc_fifo fifo_lo (
        .clk(clk), .reset_L(reset_L),
        .push(push_lo), .pop(pop_lo), .push_data(push_data),
        .read_data(read_lo), .read_valid(valid_lo), .status(status_lo)
    );

    priority_arbiter u_arbiter (
        .empty_hi(status_hi.empty), .empty_lo(status_lo.empty), .hold(hold),
        .pop_hi(pop_hi), .pop_lo(pop_lo),
        .read_hi(read_hi), .read_lo(read_lo),
        .valid_hi(valid_hi), .valid_lo(valid_lo), .read_word(read_word)
    );

    // Output side
    dest_router u_router (
        .clk(clk), .reset_L(reset_L), .read_word(read_word),
        .dest0_data(dest0_data), .dest1_data(dest1_data),
        .dest0_valid(dest0_valid), .dest1_valid(dest1_valid)
    );

endmodule
